/* include/board_params.svh */
// Board wrapper parameters
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// Data widths
`define BOARD_STATUS_W          64
`define BOARD_COLORW            4
`define BOARD_OUTW              8
`define BOARD_JOYW              10
`define BOARD_BTN_W             2

// Game side sees pressed buttons as zero
`define BOARD_INPUTS_ACTIVE_LOW 1

// OSD status bit positions
`define BOARD_ST_ROTATE         1
`define BOARD_ST_SCANLINES      3
`define BOARD_ST_FXLEVEL        6
`define BOARD_ST_NOFM           8
`define BOARD_ST_NOPSG          9
`define BOARD_ST_TEST           10
`define BOARD_ST_PAUSE          11
`define BOARD_ST_FLIP           12
`define BOARD_ST_AUTOFIRE       18

// Joystick bit of button 0
`define BOARD_FIRE_BIT          4

`endif

/* source/board_pkg.sv */
// Board wrapper types
`include "board_params.svh"

package board_pkg;

    // Raw OSD status word
    typedef logic [`BOARD_STATUS_W-1:0] status_word_t;

    // Bits 3..0 directions, bits 9..4 buttons
    typedef logic [`BOARD_JOYW-1:0] joy_t;

    // One bit per player
    typedef logic [`BOARD_BTN_W-1:0] btn_t;

    // Colour components
    typedef logic [`BOARD_COLORW-1:0] color_t;
    typedef logic [`BOARD_OUTW-1:0]   color8_t;

    // Decoded OSD settings, 13 bits
    typedef struct packed {
        logic [1:0] rotate;
        logic [2:0] scanlines;
        logic [1:0] fxlevel;
        logic       enable_fm;
        logic       enable_psg;
        logic       dip_test;
        logic       osd_pause;
        logic       dip_flip;
        logic       autofire;
    } board_settings_t;

    // Game pixel
    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } game_rgb_t;

    // Widened pixel
    typedef struct packed {
        color8_t r;
        color8_t g;
        color8_t b;
    } out_rgb_t;

endpackage

/* source/board_status_decode.sv */
// OSD status decoder
`timescale 1ns/100ps
`include "board_params.svh"

module board_status_decode (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  board_pkg::status_word_t    status,
    output board_pkg::board_settings_t settings
);
    import board_pkg::*;

    // Sound enabled, everything else off
    localparam board_settings_t SETTINGS_RST = '{
        enable_fm:  1'b1,
        enable_psg: 1'b1,
        default:    '0
    };

    board_settings_t decoded;

    always_comb begin
        decoded.rotate     = status[`BOARD_ST_ROTATE +: 2];
        decoded.scanlines  = status[`BOARD_ST_SCANLINES +: 3];
        decoded.fxlevel    = status[`BOARD_ST_FXLEVEL +: 2];
        // The OSD stores sound disables
        decoded.enable_fm  = ~status[`BOARD_ST_NOFM];
        decoded.enable_psg = ~status[`BOARD_ST_NOPSG];
        decoded.dip_test   = status[`BOARD_ST_TEST];
        decoded.osd_pause  = status[`BOARD_ST_PAUSE];
        decoded.dip_flip   = status[`BOARD_ST_FLIP];
        decoded.autofire   = status[`BOARD_ST_AUTOFIRE];
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            settings <= SETTINGS_RST;
        end else begin
            settings <= decoded;
        end
    end

    // FM enable follows the status bit one cycle later
    a_fm_follow: assert property (
        @(posedge clk_sys) disable iff (rst)
        !rst |=> settings.enable_fm == ~$past(status[`BOARD_ST_NOFM])
    ) else $error("enable_fm does not track the NOFM status bit");

endmodule

/* source/board_input_map.sv */
// Player input mapping
`timescale 1ns/100ps
`include "board_params.svh"

module board_input_map (
    input  logic            clk_sys,
    input  logic            rst,
    input  logic            vs,
    input  logic            downloading,
    input  logic            board_pause,
    input  logic            autofire,
    input  logic            osd_pause,
    input  board_pkg::joy_t board_joystick1,
    input  board_pkg::joy_t board_joystick2,
    input  board_pkg::btn_t board_coin,
    input  board_pkg::btn_t board_start,
    output board_pkg::joy_t game_joystick1,
    output board_pkg::joy_t game_joystick2,
    output board_pkg::btn_t game_coin,
    output board_pkg::btn_t game_start,
    output logic            dip_pause
);
    import board_pkg::*;

    localparam logic POL     = 1'(`BOARD_INPUTS_ACTIVE_LOW);
    // Levels seen by the game with nothing pressed
    localparam joy_t JOY_REL = {`BOARD_JOYW{POL}};
    localparam btn_t BTN_REL = {`BOARD_BTN_W{POL}};

    logic vs_l;
    logic pause_l;
    logic fire_phase;
    logic pause_tgl;
    logic fire_gate;

    function automatic joy_t map_joy(input joy_t board, input logic hold, input logic gate);
        joy_t press;
        press = hold ? '0 : board;
        press[`BOARD_FIRE_BIT] = press[`BOARD_FIRE_BIT] & gate;
        return press ^ JOY_REL;
    endfunction

    function automatic btn_t map_btn(input btn_t board, input logic hold);
        btn_t press;
        press = hold ? '0 : board;
        return press ^ BTN_REL;
    endfunction

    // Held fire only reaches the game on every other frame
    assign fire_gate = ~autofire | fire_phase;

    // Edge detectors, autofire phase and pause toggle
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vs_l       <= 1'b0;
            pause_l    <= 1'b0;
            fire_phase <= 1'b0;
            pause_tgl  <= 1'b0;
        end else begin
            vs_l    <= vs;
            pause_l <= board_pause;
            if (vs && !vs_l) begin
                fire_phase <= ~fire_phase;
            end
            if (board_pause && !pause_l) begin
                pause_tgl <= ~pause_tgl;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= JOY_REL;
            game_joystick2 <= JOY_REL;
            game_coin      <= BTN_REL;
            game_start     <= BTN_REL;
        end else begin
            game_joystick1 <= map_joy(board_joystick1, downloading, fire_gate);
            game_joystick2 <= map_joy(board_joystick2, downloading, fire_gate);
            game_coin      <= map_btn(board_coin, downloading);
            game_start     <= map_btn(board_start, downloading);
        end
    end

    assign dip_pause = pause_tgl | osd_pause;

    // Nothing reaches the game while a ROM loads
    a_download_hold: assert property (
        @(posedge clk_sys) disable iff (rst)
        downloading |=> game_joystick1 == JOY_REL && game_joystick2 == JOY_REL &&
                        game_coin == BTN_REL && game_start == BTN_REL
    ) else $error("game inputs pressed during download");

endmodule

/* source/board_video_out.sv */
// Video output stage
`timescale 1ns/100ps

module board_video_out (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic                 LHBL,
    input  logic                 LVBL,
    input  logic [2:0]           scanlines,
    input  board_pkg::game_rgb_t game_rgb,
    output board_pkg::out_rgb_t  base_rgb,
    output logic                 base_lhbl,
    output logic                 base_lvbl,
    output logic                 video_de
);
    import board_pkg::*;

    logic       lhbl_l;
    logic       odd_line;
    logic       active;
    logic [1:0] sl_mode;
    out_rgb_t   wide_rgb;
    out_rgb_t   pix_rgb;

    // Bit replication keeps full white at full scale
    function automatic color8_t widen(input color_t c);
        return {c, c};
    endfunction

    function automatic color8_t dim(input color8_t v, input logic [1:0] mode);
        case (mode)
            2'd1:    return v - (v >> 2);
            2'd2:    return v >> 1;
            2'd3:    return v >> 2;
            default: return v;
        endcase
    endfunction

    assign sl_mode = scanlines[1:0];
    assign active  = LHBL & LVBL;

    always_comb begin
        wide_rgb.r = widen(game_rgb.r);
        wide_rgb.g = widen(game_rgb.g);
        wide_rgb.b = widen(game_rgb.b);
        pix_rgb    = wide_rgb;
        // Odd lines darker, parity from before this strobe
        if (odd_line) begin
            pix_rgb.r = dim(wide_rgb.r, sl_mode);
            pix_rgb.g = dim(wide_rgb.g, sl_mode);
            pix_rgb.b = dim(wide_rgb.b, sl_mode);
        end
        if (!active) begin
            pix_rgb = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            base_rgb  <= '0;
            base_lhbl <= 1'b0;
            base_lvbl <= 1'b0;
            video_de  <= 1'b0;
            lhbl_l    <= 1'b0;
            odd_line  <= 1'b0;
        end else if (pxl_cen) begin
            base_rgb  <= pix_rgb;
            base_lhbl <= LHBL;
            base_lvbl <= LVBL;
            video_de  <= active;
            lhbl_l    <= LHBL;
            // Count lines on the start of horizontal blank
            if (!LVBL) begin
                odd_line <= 1'b0;
            end else if (lhbl_l && !LHBL) begin
                odd_line <= ~odd_line;
            end
        end
    end

    a_blank_black: assert property (
        @(posedge clk_sys) disable iff (rst)
        !video_de |-> base_rgb == '0
    ) else $error("colour present outside the active area");

endmodule

/* source/board_frame.sv */
// Board wrapper top level
`timescale 1ns/100ps

module board_frame (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  board_pkg::status_word_t  status,
    // Inputs
    input  logic                     vs,
    input  logic                     downloading,
    input  logic                     board_pause,
    input  board_pkg::joy_t          board_joystick1,
    input  board_pkg::joy_t          board_joystick2,
    input  board_pkg::btn_t          board_coin,
    input  board_pkg::btn_t          board_start,
    output board_pkg::joy_t          game_joystick1,
    output board_pkg::joy_t          game_joystick2,
    output board_pkg::btn_t          game_coin,
    output board_pkg::btn_t          game_start,
    output logic                     dip_pause,
    // Video
    input  logic                     pxl_cen,
    input  logic                     LHBL,
    input  logic                     LVBL,
    input  board_pkg::game_rgb_t     game_rgb,
    output board_pkg::out_rgb_t      base_rgb,
    output logic                     base_lhbl,
    output logic                     base_lvbl,
    output logic                     video_de,
    // Settings for the game
    output logic [1:0]               rotate,
    output logic [2:0]               scanlines,
    output logic [1:0]               dip_fxlevel,
    output logic                     enable_fm,
    output logic                     enable_psg,
    output logic                     dip_test,
    output logic                     dip_flip
);
    import board_pkg::*;

    board_settings_t settings;

    assign rotate      = settings.rotate;
    assign scanlines   = settings.scanlines;
    assign dip_fxlevel = settings.fxlevel;
    assign enable_fm   = settings.enable_fm;
    assign enable_psg  = settings.enable_psg;
    assign dip_test    = settings.dip_test;
    assign dip_flip    = settings.dip_flip;

    board_status_decode u_decode (
        .clk_sys  ( clk_sys  ),
        .rst      ( rst      ),
        .status   ( status   ),
        .settings ( settings )
    );

    board_input_map u_inputs (
        .clk_sys         ( clk_sys            ),
        .rst             ( rst                ),
        .vs              ( vs                 ),
        .downloading     ( downloading        ),
        .board_pause     ( board_pause        ),
        .autofire        ( settings.autofire  ),
        .osd_pause       ( settings.osd_pause ),
        .board_joystick1 ( board_joystick1    ),
        .board_joystick2 ( board_joystick2    ),
        .board_coin      ( board_coin         ),
        .board_start     ( board_start        ),
        .game_joystick1  ( game_joystick1     ),
        .game_joystick2  ( game_joystick2     ),
        .game_coin       ( game_coin          ),
        .game_start      ( game_start         ),
        .dip_pause       ( dip_pause          )
    );

    board_video_out u_video (
        .clk_sys   ( clk_sys            ),
        .rst       ( rst                ),
        .pxl_cen   ( pxl_cen            ),
        .LHBL      ( LHBL               ),
        .LVBL      ( LVBL               ),
        .scanlines ( settings.scanlines ),
        .game_rgb  ( game_rgb           ),
        .base_rgb  ( base_rgb           ),
        .base_lhbl ( base_lhbl          ),
        .base_lvbl ( base_lvbl          ),
        .video_de  ( video_de           )
    );

endmodule

/* test/board_frame_tb.sv */
// Board wrapper testbench
`timescale 1ns/100ps
`include "board_params.svh"

module board_frame_tb;
    import board_pkg::*;

    // Roughly 1000 clock cycles of tests, with ample margin
    localparam int WATCHDOG_NS = 20000;

    logic clk_sys = 1'b0;
    logic rst, vs, downloading, board_pause, pxl_cen, LHBL, LVBL;
    status_word_t status;
    joy_t board_joystick1, board_joystick2, game_joystick1, game_joystick2;
    btn_t board_coin, board_start, game_coin, game_start;
    game_rgb_t game_rgb;
    out_rgb_t base_rgb;
    logic dip_pause, base_lhbl, base_lvbl, video_de;
    logic [1:0] rotate, dip_fxlevel;
    logic [2:0] scanlines;
    logic enable_fm, enable_psg, dip_test, dip_flip;
    integer seed = 67;
    int checks = 0;
    int errors = 0;

    board_frame dut0 (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // Pixel strobe on every second cycle
    always @(negedge clk_sys) pxl_cen <= ~pxl_cen;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    task automatic check_value(input string sig, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, sig, exp, act);
        end
    endtask

    // Returns at the falling edge just before a strobed rising edge
    task automatic wait_strobe();
        @(negedge clk_sys);
        if (pxl_cen) @(negedge clk_sys);
    endtask

    function automatic logic [7:0] shade(input logic [3:0] c, input logic odd,
                                         input logic [1:0] mode, input logic de);
        int v;
        v = c * 17;
        if (!de) return 8'h00;
        if (odd) begin
            case (mode)
                2'd1:    v = v - v / 4;
                2'd2:    v = v / 2;
                2'd3:    v = v / 4;
                default: ;
            endcase
        end
        return v[7:0];
    endfunction

    task automatic test_status();
        logic [63:0] st;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_sys);
            st = {$random(seed), $random(seed)};
            status = st;
            repeat (2) @(negedge clk_sys);
            check_value("rotate", st[2:1], rotate);
            check_value("scanlines", st[5:3], scanlines);
            check_value("dip_fxlevel", st[7:6], dip_fxlevel);
            check_value("enable_fm", !st[8], enable_fm);
            check_value("enable_psg", !st[9], enable_psg);
            check_value("dip_test", st[10], dip_test);
            check_value("dip_flip", st[12], dip_flip);
        end
        @(negedge clk_sys);
        status = '0;
    endtask

    task automatic test_joystick();
        joy_t j1, j2;
        btn_t c, s;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_sys);
            j1 = $random(seed);
            j2 = $random(seed);
            c = $random(seed);
            s = $random(seed);
            board_joystick1 = j1;
            board_joystick2 = j2;
            board_coin = c;
            board_start = s;
            downloading = (i >= 12);
            repeat (2) @(negedge clk_sys);
            check_value("game_joystick1", downloading ? 10'h3ff : joy_t'(~j1), game_joystick1);
            check_value("game_joystick2", downloading ? 10'h3ff : joy_t'(~j2), game_joystick2);
            check_value("game_coin", downloading ? 2'b11 : btn_t'(~c), game_coin);
            check_value("game_start", downloading ? 2'b11 : btn_t'(~s), game_start);
        end
        @(negedge clk_sys);
        {downloading, board_joystick1, board_joystick2, board_coin, board_start} = '0;
    endtask

    task automatic test_autofire();
        joy_t fire;
        logic phase;
        fire = 10'(1) << `BOARD_FIRE_BIT;
        // No vs edge has been seen since reset
        phase = 1'b0;
        @(negedge clk_sys);
        status = 64'(1) << `BOARD_ST_AUTOFIRE;
        board_joystick1 = fire;
        for (int i = 0; i < 12; i++) begin
            if (i == 6) status = '0;
            @(negedge clk_sys);
            vs = 1'b1;
            phase = ~phase;
            @(negedge clk_sys);
            vs = 1'b0;
            @(negedge clk_sys);
            check_value("game_joystick1",
                        (i < 6 && !phase) ? 10'h3ff : joy_t'(~fire), game_joystick1);
        end
        board_joystick1 = '0;
    endtask

    task automatic test_pause();
        logic tgl;
        tgl = 1'b0;
        for (int i = 0; i < 6; i++) begin
            if (i == 4) status = 64'(1) << `BOARD_ST_PAUSE;
            @(negedge clk_sys);
            board_pause = 1'b1;
            @(negedge clk_sys);
            board_pause = 1'b0;
            tgl = ~tgl;
            @(negedge clk_sys);
            check_value("dip_pause", (i >= 4) ? 1'b1 : tgl, dip_pause);
        end
        status = '0;
        repeat (2) @(negedge clk_sys);
        check_value("dip_pause", tgl, dip_pause);
    endtask

    task automatic test_video();
        logic odd, hb_l, vb_l, hb, vb, exp_de;
        out_rgb_t exp_rgb;
        game_rgb_t pix;
        logic [1:0] mode;
        // Earlier tests kept both blanks low, so parity is clear
        odd = 1'b0;
        hb_l = 1'b0;
        vb_l = 1'b0;
        exp_rgb = '0;
        exp_de = 1'b0;
        for (int m = 0; m < 4; m++) begin
            mode = m;
            @(negedge clk_sys);
            status = 64'(mode) << `BOARD_ST_SCANLINES;
            for (int line = 0; line < 6; line++) begin
                for (int px = 0; px < 10; px++) begin
                    hb = (px < 8);
                    vb = (line < 4);
                    pix = $random(seed);
                    wait_strobe();
                    check_value("base_rgb", exp_rgb, base_rgb);
                    check_value("video_de", exp_de, video_de);
                    check_value("base_lhbl", hb_l, base_lhbl);
                    check_value("base_lvbl", vb_l, base_lvbl);
                    LHBL = hb;
                    LVBL = vb;
                    game_rgb = pix;
                    exp_de = hb & vb;
                    exp_rgb.r = shade(pix.r, odd, mode, exp_de);
                    exp_rgb.g = shade(pix.g, odd, mode, exp_de);
                    exp_rgb.b = shade(pix.b, odd, mode, exp_de);
                    if (!vb) odd = 1'b0;
                    else if (hb_l && !hb) odd = ~odd;
                    hb_l = hb;
                    vb_l = vb;
                end
            end
        end
        wait_strobe();
        check_value("base_rgb", exp_rgb, base_rgb);
        check_value("video_de", exp_de, video_de);
        check_value("base_lhbl", hb_l, base_lhbl);
        check_value("base_lvbl", vb_l, base_lvbl);
    endtask

    initial begin
        rst = 1'b1;
        pxl_cen = 1'b0;
        {vs, downloading, board_pause, LHBL, LVBL} = '0;
        {board_joystick1, board_joystick2, board_coin, board_start} = '0;
        status = '0;
        game_rgb = '0;
        repeat (4) @(negedge clk_sys);
        rst = 1'b0;
        @(negedge clk_sys);
        check_value("game_joystick1", 10'h3ff, game_joystick1);
        test_status();
        test_joystick();
        test_autofire();
        test_pause();
        test_video();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("All tests passed");
        else $display("Some tests failed");
        $finish;
    end

endmodule

/* board_frame.f */
+incdir+include
source/board_pkg.sv
source/board_status_decode.sv
source/board_input_map.sv
source/board_video_out.sv
source/board_frame.sv
test/board_frame_tb.sv
